// File: source/subCpu_defines.svh
`ifndef SUBCPU_DEFINES_SVH
`define SUBCPU_DEFINES_SVH

//////////////////////////////////////////////////
// Watchdog
//////////////////////////////////////////////////

// Counter width, top bit drives the sub-CPU reset
`define WATCHDOG_WIDTH 4

// Decade-style wrap, count returns to zero here
`define WATCHDOG_LIMIT 10

//////////////////////////////////////////////////
// Address codes on A15..A10
//////////////////////////////////////////////////

// 8000h write, watchdog kick
`define ADDR_WDOG 6'b100000
// 8400h write, interrupt acknowledge
`define ADDR_IRQACK 6'b100001
// 8800h write, tile bank strobe
`define ADDR_BANK 6'b100010
// 9000h, scroll and priority latch 0
`define ADDR_LTH0 6'b100100
// 9400h, scroll and priority latch 1
`define ADDR_LTH1 6'b100101
// A000h, back colour latch
`define ADDR_LTH2 6'b101000
// 4000h, shared RAM with the sound CPU
`define ADDR_SND 6'b010000

`endif

// File: source/subCpuPkg.sv
package subCpuPkg;

`include "subCpu_defines.svh"

	// A15 down to A10 of the sub-CPU address bus
	typedef logic [5:0] addrHigh_t;

	// Decoded selects, active high inside the design
	// Bit order from MSB: scr0 scr1 obj snd lth0 lth1 lth2 spgm mpgm bank bufEn
	typedef logic [10:0] selectVec_t;

	// Vertical-blank watchdog count
	typedef logic [`WATCHDOG_WIDTH-1:0] wdCount_t;

	//////////////////////////////////////////////////
	// Bit positions inside selectVec_t
	//////////////////////////////////////////////////

	localparam int SEL_SCR0 = 10;
	localparam int SEL_SCR1 = 9;
	localparam int SEL_OBJ = 8;
	localparam int SEL_SND = 7;
	localparam int SEL_LTH0 = 6;
	localparam int SEL_LTH1 = 5;
	localparam int SEL_LTH2 = 4;
	localparam int SEL_SPGM = 3;
	localparam int SEL_MPGM = 2;
	localparam int SEL_BANK = 1;
	localparam int SEL_BUFEN = 0;

endpackage

// File: source/subCpuIf.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Captured bus cycle
//////////////////////////////////////////////////

interface busIf import subCpuPkg::*; ();

	// Upper address lines of the cycle
	addrHigh_t address;
	// Active-high write, already inverted from nWe
	logic write;
	// One-cycle strobe, a cycle is only meaningful with it
	logic valid;

	// Capture side
	modport source (
		output address,
		output write,
		output valid
	);

	// Decode side
	modport sink (
		input address,
		input write,
		input valid
	);

endinterface

//////////////////////////////////////////////////
// Decoded result
//////////////////////////////////////////////////

interface selectIf import subCpuPkg::*; ();

	// Chip selects, active high, already gated by valid
	selectVec_t selects;
	// Command pulses from writes to 8000h and 8400h
	logic wdKick;
	logic irqAck;
	// Marks the cycle the decode belongs to
	logic valid;

	modport source (
		output selects,
		output wdKick,
		output irqAck,
		output valid
	);

	// Shared by the output stage and the watchdog
	modport sink (
		input selects,
		input wdKick,
		input irqAck,
		input valid
	);

endinterface

// File: source/cpuBusCapture.sv
`timescale 1ns/1ps

module cpuBusCapture import subCpuPkg::*; (
	input logic nVBLK,
	input logic arstN,
	input addrHigh_t addr,
	input logic nWe,
	input logic busValid,
	busIf.source bus
);

	// Registered copy of the bus pins
	addrHigh_t addrQ;
	logic writeQ;
	logic validQ;

	//////////////////////////////////////////////////
	// Strobe register
	//////////////////////////////////////////////////

	// Cleared on reset so no stale cycle reaches the decoder
	always_ff @(posedge nVBLK or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= busValid;
		end
	end

	//////////////////////////////////////////////////
	// Address and direction
	//////////////////////////////////////////////////

	// Sampled every edge, only read when validQ is set
	always_ff @(posedge nVBLK) begin
		addrQ <= addr;
		// Write strobe is active low on the pin
		writeQ <= ~nWe;
	end

	// Hand the stable cycle to the decoder
	assign bus.address = addrQ;
	assign bus.write = writeQ;
	assign bus.valid = validQ;

endmodule

// File: source/subAddressDecoder.sv
`timescale 1ns/1ps

`include "subCpu_defines.svh"

module subAddressDecoder import subCpuPkg::*; (
	busIf.sink bus,
	selectIf.source sel
);

	// Raw decode before the strobe is applied
	selectVec_t decoded;
	addrHigh_t a;
	logic wr;
	logic rd;

	assign a = bus.address;
	assign wr = bus.write;
	assign rd = ~bus.write;

	//////////////////////////////////////////////////
	// Memory map
	//////////////////////////////////////////////////

	always_comb begin
		decoded = '0;

		// 0000h-1FFFh, video RAM 0, write only
		decoded[SEL_SCR0] = (a[5:3] == 3'b000) && wr;

		// 2000h-3FFFh, video RAM 1, write only
		decoded[SEL_SCR1] = (a[5:3] == 3'b001) && wr;

		// 4000h-5FFFh, sprite RAM
		decoded[SEL_OBJ] = (a[5:3] == 3'b010);

		// 4000h-43FFh, sound shared RAM
		// Sits inside the sprite window, both selects fire together
		decoded[SEL_SND] = (a == `ADDR_SND);

		// 6000h-7FFFh, program ROM 9D, reads only
		decoded[SEL_SPGM] = (a[5:3] == 3'b011) && rd;

		// 8000h-FFFFh, program ROM 9C, reads only
		decoded[SEL_MPGM] = a[5] && rd;

		// 8800h, tile bank strobe on write
		decoded[SEL_BANK] = (a == `ADDR_BANK) && wr;

		// Scroll and priority latches, any direction
		decoded[SEL_LTH0] = (a == `ADDR_LTH0);
		decoded[SEL_LTH1] = (a == `ADDR_LTH1);
		decoded[SEL_LTH2] = (a == `ADDR_LTH2);

		// Data buffer opens for any target on the shared video bus
		decoded[SEL_BUFEN] = decoded[SEL_SCR0] | decoded[SEL_SCR1]
			| decoded[SEL_OBJ] | decoded[SEL_SND]
			| decoded[SEL_LTH0] | decoded[SEL_LTH1];
	end

	//////////////////////////////////////////////////
	// Strobe gating and commands
	//////////////////////////////////////////////////

	// No strobe means every select idles
	assign sel.selects = bus.valid ? decoded : '0;

	// Write to 8000h kicks the watchdog
	assign sel.wdKick = bus.valid && wr && (a == `ADDR_WDOG);

	// Write to 8400h acknowledges the vblank interrupt
	assign sel.irqAck = bus.valid && wr && (a == `ADDR_IRQACK);

	// Cycle marker for downstream blocks
	assign sel.valid = bus.valid;

endmodule

// File: source/vblankWatchdog.sv
`timescale 1ns/1ps

`include "subCpu_defines.svh"

module vblankWatchdog import subCpuPkg::*; (
	input logic nVBLK,
	input logic arstN,
	input logic vblankTick,
	selectIf.sink sel,
	output logic nRes,
	output logic nIrq
);

	localparam wdCount_t WD_LIMIT = wdCount_t'(`WATCHDOG_LIMIT);

	wdCount_t count;
	wdCount_t countNext;

	//////////////////////////////////////////////////
	// Watchdog counter
	//////////////////////////////////////////////////

	always_comb begin
		countNext = count;
		// Kick beats a tick on the same edge
		if (sel.wdKick) begin
			countNext = '0;
		end else if (vblankTick) begin
			// Wrap at the limit, reset drops again
			if (count == WD_LIMIT) begin
				countNext = '0;
			end else begin
				countNext = count + 1'b1;
			end
		end
	end

	// Reset follows the top bit, held low through counts 8..10 at width 4
	always_ff @(posedge nVBLK or negedge arstN) begin
		if (!arstN) begin
			count <= '0;
			nRes <= 1'b1;
		end else begin
			count <= countNext;
			nRes <= ~countNext[`WATCHDOG_WIDTH-1];
		end
	end

	//////////////////////////////////////////////////
	// Interrupt flag
	//////////////////////////////////////////////////

	// Set by vblank, cleared by the acknowledge write
	always_ff @(posedge nVBLK or negedge arstN) begin
		if (!arstN) begin
			nIrq <= 1'b1;
		end else if (sel.irqAck) begin
			// Acknowledge wins a tie with the tick
			nIrq <= 1'b1;
		end else if (vblankTick) begin
			nIrq <= 1'b0;
		end
	end

endmodule

// File: source/selectOutputStage.sv
`timescale 1ns/1ps

module selectOutputStage import subCpuPkg::*; (
	input logic nVBLK,
	input logic arstN,
	selectIf.sink sel,
	output logic nScr0,
	output logic nScr1,
	output logic nObj,
	output logic nSnd,
	output logic nLth0,
	output logic nLth1,
	output logic nLth2,
	output logic nSpgm,
	output logic nMpgm,
	output logic bank,
	output logic nBufEn
);

	// Registered selects, active high
	selectVec_t selQ;

	//////////////////////////////////////////////////
	// Select register
	//////////////////////////////////////////////////

	// Loads on a new cycle or to fall back to idle
	// Otherwise the register already holds all-inactive
	always_ff @(posedge nVBLK or negedge arstN) begin
		if (!arstN) begin
			selQ <= '0;
		end else if (sel.valid || (selQ != '0)) begin
			selQ <= sel.selects;
		end
	end

	//////////////////////////////////////////////////
	// Pins
	//////////////////////////////////////////////////

	// Straight from flops, no decode glitches on the pins
	assign nScr0 = ~selQ[SEL_SCR0];
	assign nScr1 = ~selQ[SEL_SCR1];
	assign nObj = ~selQ[SEL_OBJ];
	assign nSnd = ~selQ[SEL_SND];
	assign nLth0 = ~selQ[SEL_LTH0];
	assign nLth1 = ~selQ[SEL_LTH1];
	assign nLth2 = ~selQ[SEL_LTH2];
	assign nSpgm = ~selQ[SEL_SPGM];
	assign nMpgm = ~selQ[SEL_MPGM];
	// Bank is the only active-high strobe
	assign bank = selQ[SEL_BANK];
	assign nBufEn = ~selQ[SEL_BUFEN];

endmodule

// File: source/subCpuGlue.sv
`timescale 1ns/1ps

module subCpuGlue (
	input logic nVBLK,
	input logic arstN,
	input logic [5:0] addr,
	input logic nWe,
	input logic busValid,
	input logic vblankTick,
	output logic nScr0,
	output logic nScr1,
	output logic nObj,
	output logic nSnd,
	output logic nLth0,
	output logic nLth1,
	output logic nLth2,
	output logic nSpgm,
	output logic nMpgm,
	output logic bank,
	output logic nBufEn,
	output logic nRes,
	output logic nIrq
);

	//////////////////////////////////////////////////
	// Internal buses
	//////////////////////////////////////////////////

	// Capture to decode
	busIf busSig ();
	// Decode to output stage and watchdog
	selectIf selSig ();

	//////////////////////////////////////////////////
	// Pipeline
	//////////////////////////////////////////////////

	// Edge k, pins into a stable cycle
	cpuBusCapture busCapture (
		.nVBLK(nVBLK),
		.arstN(arstN),
		.addr(addr),
		.nWe(nWe),
		.busValid(busValid),
		.bus(busSig.source)
	);

	// Same cycle, memory map and commands
	subAddressDecoder addrDecoder (
		.bus(busSig.sink),
		.sel(selSig.source)
	);

	// Kick and acknowledge land at edge k+1
	vblankWatchdog watchdog (
		.nVBLK(nVBLK),
		.arstN(arstN),
		.vblankTick(vblankTick),
		.sel(selSig.sink),
		.nRes(nRes),
		.nIrq(nIrq)
	);

	// Edge k+1, selects onto the pins
	selectOutputStage outStage (
		.nVBLK(nVBLK),
		.arstN(arstN),
		.sel(selSig.sink),
		.nScr0(nScr0),
		.nScr1(nScr1),
		.nObj(nObj),
		.nSnd(nSnd),
		.nLth0(nLth0),
		.nLth1(nLth1),
		.nLth2(nLth2),
		.nSpgm(nSpgm),
		.nMpgm(nMpgm),
		.bank(bank),
		.nBufEn(nBufEn)
	);

endmodule

// File: testbench/subCpuGlue_properties.sv
`timescale 1ns/1ps

module subCpuGlue_properties (
	input logic nVBLK,
	input logic arstN,
	input logic busValid,
	input logic nScr0,
	input logic nScr1,
	input logic nObj,
	input logic nSnd,
	input logic nLth0,
	input logic nLth1,
	input logic nLth2,
	input logic nSpgm,
	input logic nMpgm,
	input logic bank,
	input logic nBufEn,
	input logic nRes,
	input logic nIrq
);

	// Every select pin idle, bank strobe low
	logic allIdle;
	assign allIdle = nScr0 & nScr1 & nObj & nSnd & nLth0 & nLth1 & nLth2
		& nSpgm & nMpgm & nBufEn & ~bank;

	//////////////////////////////////////////////////
	// Reset
	//////////////////////////////////////////////////

	afterReset: assert property (@(posedge nVBLK) $rose(arstN) |-> (nRes && nIrq))
		else $error("nRes or nIrq low in the first cycle after reset");

	duringReset: assert property (@(posedge nVBLK) !arstN |-> (nRes && nIrq))
		else $error("nRes or nIrq low while reset is held");

	//////////////////////////////////////////////////
	// Selects
	//////////////////////////////////////////////////

	// Two edges of latency from strobe to pins
	noStrobeIdle: assert property (@(posedge nVBLK) disable iff (!arstN)
		!$past(busValid, 2) |-> allIdle)
		else $error("select active without a bus strobe");

	bufEnSources: assert property (@(posedge nVBLK)
		nBufEn == (nScr0 & nScr1 & nObj & nSnd & nLth0 & nLth1))
		else $error("buffer enable does not match its source selects");

endmodule

bind subCpuGlue subCpuGlue_properties props_i (.*);

// File: testbench/subCpuGlue_tb.sv
`timescale 1ns/1ps

`include "subCpu_defines.svh"

module subCpuGlue_tb import subCpuPkg::*; ();

	// DUT inputs
	logic nVBLK;
	logic arstN;
	addrHigh_t addr;
	logic nWe;
	logic busValid;
	logic vblankTick;
	// DUT outputs
	logic nScr0;
	logic nScr1;
	logic nObj;
	logic nSnd;
	logic nLth0;
	logic nLth1;
	logic nLth2;
	logic nSpgm;
	logic nMpgm;
	logic bank;
	logic nBufEn;
	logic nRes;
	logic nIrq;

	// One bus cycle of the table and the selects it must produce
	typedef struct packed {
		addrHigh_t addr;
		logic write;
		logic tick;
		selectVec_t expSel;
	} stimRow_t;

	localparam int NUM_ROWS = 20;

	// Bit order scr0 scr1 obj snd lth0 lth1 lth2 spgm mpgm bank bufEn
	stimRow_t stimTable [NUM_ROWS] = '{
		'{6'b000000, 1'b1, 1'b0, 11'b10000000001},
		'{6'b000111, 1'b0, 1'b0, 11'b00000000000},
		'{6'b001000, 1'b0, 1'b1, 11'b00000000000},
		'{6'b001111, 1'b1, 1'b0, 11'b01000000001},
		'{`ADDR_SND, 1'b0, 1'b0, 11'b00110000001},
		'{`ADDR_SND, 1'b1, 1'b0, 11'b00110000001},
		'{6'b010100, 1'b1, 1'b0, 11'b00100000001},
		'{6'b011000, 1'b0, 1'b0, 11'b00000001000},
		'{6'b011000, 1'b1, 1'b1, 11'b00000000000},
		'{`ADDR_WDOG, 1'b0, 1'b0, 11'b00000000100},
		'{`ADDR_IRQACK, 1'b1, 1'b0, 11'b00000000000},
		'{`ADDR_BANK, 1'b1, 1'b0, 11'b00000000010},
		'{`ADDR_BANK, 1'b0, 1'b0, 11'b00000000100},
		'{`ADDR_LTH0, 1'b0, 1'b0, 11'b00001000101},
		'{`ADDR_LTH0, 1'b1, 1'b0, 11'b00001000001},
		'{`ADDR_LTH1, 1'b1, 1'b1, 11'b00000100001},
		'{`ADDR_LTH1, 1'b0, 1'b0, 11'b00000100101},
		'{`ADDR_LTH2, 1'b0, 1'b0, 11'b00000010100},
		'{`ADDR_LTH2, 1'b1, 1'b0, 11'b00000010000},
		'{`ADDR_WDOG, 1'b1, 1'b0, 11'b00000000000}
	};

	// Reference watchdog count and interrupt level
	wdCount_t modelCount;
	logic modelIrq;
	integer seed;
	logic [31:0] rv;
	int i;

	subCpuGlue dut_i (.*);

	// 20 ns period
	always #10 nVBLK = ~nVBLK;

	//////////////////////////////////////////////////
	// Reference model and checks
	//////////////////////////////////////////////////

	// Pins folded back into the active-high select order
	function automatic selectVec_t pinSelects();
		return {~nScr0, ~nScr1, ~nObj, ~nSnd, ~nLth0, ~nLth1,
			~nLth2, ~nSpgm, ~nMpgm, bank, ~nBufEn};
	endfunction

	// One vblank tick, wraps to zero at the limit
	function automatic wdCount_t nextCount(input wdCount_t c);
		if (c == wdCount_t'(`WATCHDOG_LIMIT)) begin
			return '0;
		end
		return c + wdCount_t'(1);
	endfunction

	task automatic checkSelects(input selectVec_t expected);
		selectVec_t actual;
		actual = pinSelects();
		if (actual !== expected) begin
			$display("ERROR %0t selects expected %b actual %b", $time, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic checkLine(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %0t %s expected %b actual %b", $time, name, expected, actual);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// nRes shows the top bit of the count, inverted
	task automatic checkCount(input wdCount_t expected);
		if (nRes !== ~expected[`WATCHDOG_WIDTH-1]) begin
			$display("ERROR %0t nRes expected %b actual %b for count %0d",
				$time, ~expected[`WATCHDOG_WIDTH-1], nRes, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Bounded wait on nRes or nIrq, one negedge per step
	task automatic waitForLine(input string name, input logic level, input int maxCycles);
		int n;
		logic cur;
		n = 0;
		cur = (name == "nRes") ? nRes : nIrq;
		while (cur !== level && n < maxCycles) begin
			@(negedge nVBLK);
			n++;
			cur = (name == "nRes") ? nRes : nIrq;
		end
		if (cur !== level) begin
			$display("Timed out at %0t waiting for %s to reach %b", $time, name, level);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// Starts on a falling edge, returns on the falling edge after k+1
	task automatic applyCycle(input addrHigh_t a, input logic wr, input logic tick,
		input logic valid);
		addr = a;
		nWe = ~wr;
		busValid = valid;
		vblankTick = tick;
		@(posedge nVBLK);
		@(negedge nVBLK);
		// Strobe and tick last one cycle
		busValid = 1'b0;
		vblankTick = 1'b0;
		@(posedge nVBLK);
		@(negedge nVBLK);
		// Tick lands at edge k, a kick or acknowledge at edge k+1
		if (tick) begin
			modelCount = nextCount(modelCount);
			modelIrq = 1'b0;
		end
		if (valid && wr && a == `ADDR_WDOG) begin
			modelCount = '0;
		end
		if (valid && wr && a == `ADDR_IRQACK) begin
			modelIrq = 1'b1;
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		seed = 32'h3ad1_0a73;
		nVBLK = 1'b0;
		arstN = 1'b1;
		addr = '0;
		nWe = 1'b1;
		busValid = 1'b0;
		vblankTick = 1'b0;
		modelCount = '0;
		modelIrq = 1'b1;
		#2;
		arstN = 1'b0;
		repeat (4) @(posedge nVBLK);
		@(negedge nVBLK);
		arstN = 1'b1;
		checkLine("nRes", 1'b1, nRes);
		checkLine("nIrq", 1'b1, nIrq);
		checkSelects('0);

		// Memory map, overlap and read-only ROMs
		for (i = 0; i < NUM_ROWS; i++) begin
			applyCycle(stimTable[i].addr, stimTable[i].write, stimTable[i].tick, 1'b1);
			checkSelects(stimTable[i].expSel);
			checkLine("nIrq", modelIrq, nIrq);
			checkCount(modelCount);
		end

		// No strobe, random cycles select nothing and command nothing
		for (i = 0; i < 40; i++) begin
			rv = $random(seed);
			applyCycle(rv[5:0], rv[6], 1'b0, 1'b0);
			checkSelects('0);
			checkLine("nIrq", modelIrq, nIrq);
			checkCount(modelCount);
		end

		// Free-running watchdog, reset held for counts 8 to 10
		applyCycle(`ADDR_WDOG, 1'b1, 1'b0, 1'b1);
		for (i = 1; i <= 11; i++) begin
			applyCycle(6'd0, 1'b0, 1'b1, 1'b0);
			checkCount(modelCount);
			checkLine("nRes", (i >= 8 && i <= 10) ? 1'b0 : 1'b1, nRes);
		end

		// Kicked between ticks
		for (i = 0; i < 30; i++) begin
			applyCycle(6'd0, 1'b0, 1'b1, 1'b0);
			checkLine("nRes", 1'b1, nRes);
			applyCycle(`ADDR_WDOG, 1'b1, 1'b0, 1'b1);
		end

		// Interrupt acknowledge, then a fresh vblank
		applyCycle(`ADDR_IRQACK, 1'b1, 1'b0, 1'b1);
		waitForLine("nIrq", 1'b1, 3);
		applyCycle(6'd0, 1'b0, 1'b1, 1'b0);
		waitForLine("nIrq", 1'b0, 3);

		// Ack reaches the watchdog on the same edge as a tick
		addr = `ADDR_IRQACK;
		nWe = 1'b0;
		busValid = 1'b1;
		@(posedge nVBLK);
		@(negedge nVBLK);
		nWe = 1'b1;
		busValid = 1'b0;
		vblankTick = 1'b1;
		@(posedge nVBLK);
		@(negedge nVBLK);
		vblankTick = 1'b0;
		modelCount = nextCount(modelCount);
		modelIrq = 1'b1;
		checkLine("nIrq", 1'b1, nIrq);

		// Reads of 8000h and 8400h leave count and flag alone
		applyCycle(`ADDR_WDOG, 1'b1, 1'b0, 1'b1);
		repeat (7) begin
			applyCycle(6'd0, 1'b0, 1'b1, 1'b0);
		end
		applyCycle(`ADDR_WDOG, 1'b0, 1'b0, 1'b1);
		applyCycle(`ADDR_IRQACK, 1'b0, 1'b0, 1'b1);
		checkLine("nIrq", 1'b0, nIrq);
		applyCycle(6'd0, 1'b0, 1'b1, 1'b0);
		checkCount(modelCount);
		checkLine("nRes", 1'b0, nRes);

		$display("Test passed");
		$finish;
	end

endmodule

// File: subCpuGlue.f
+incdir+source
source/subCpuPkg.sv
source/subCpuIf.sv
source/cpuBusCapture.sv
source/subAddressDecoder.sv
source/vblankWatchdog.sv
source/selectOutputStage.sv
source/subCpuGlue.sv
testbench/subCpuGlue_properties.sv
testbench/subCpuGlue_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps --top-module subCpuGlue_tb \
	-f subCpuGlue.f -o subCpuGlue_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/subCpuGlue_sim > sim.log 2>&1 || echo "Simulation returned an error status"
cat sim.log
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test passed" sim.log || { echo "FAIL, run did not complete"; exit 1; }
echo "PASS"
